//--- src/rf_config.svh
`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

// lane count and field widths
`define RF_N_LANES          20
`define RF_NB_LANE_ID       5
`define RF_NB_GPIO          32
`define RF_NB_ADDR          9
`define RF_NB_DATA          22
`define RF_NB_WINDOW        12
`define RF_NB_INVALID       11
`define RF_NB_SKEW          6
`define RF_NB_COUNTER       16
`define RF_NB_TX_ENB        6
`define RF_NB_RX_ENB        7
`define RF_NB_INV_AM        3
`define RF_NB_VAL_AM        5
`define RF_NB_AM_PERIOD     14

// pcs soft reset hold time, in clock cycles
`define RF_PCS_RESET_CYCLES 16

// config register map
`define RF_ADDR_GLOBAL       0
`define RF_ADDR_TX_ENB       1
`define RF_ADDR_RX_ENB       2
`define RF_ADDR_LOCKED_TMR   3
`define RF_ADDR_UNLOCKED_TMR 4
`define RF_ADDR_SH_INVALID   5
`define RF_ADDR_ALIGNER      6
`define RF_ADDR_RESET_ORDER  7
`define RF_ADDR_BIT_SKEW     16

// status window, selected by address bit 8
`define RF_ADDR_STATUS_BASE  256
`define RF_ST_BLOCK_LOCK     0
`define RF_ST_AM_LOCK        1
`define RF_ST_HI_BER         2
`define RF_ST_DESKEW_DONE    3
`define RF_ST_MISMATCH       4
`define RF_ST_DECODER_ERR    5
`define RF_ST_LANE_ID_BASE   8

`endif

//--- src/rf_pkg.sv
`include "rf_config.svh"

package rf_pkg;

    // lane-tagged view of the data field, lane in the low bits
    typedef struct packed {
        logic [`RF_NB_DATA-`RF_NB_SKEW-`RF_NB_LANE_ID-1:0] reserved;
        logic [`RF_NB_SKEW-1:0]                           skew;
        logic [`RF_NB_LANE_ID-1:0]                        lane;
    } lane_cmd_t;

    typedef union packed {
        logic [`RF_NB_DATA-1:0] raw;
        lane_cmd_t              lane_cmd;
    } rf_data_u;

    // word written by the soft processor
    typedef struct packed {
        logic                   strobe;
        logic [`RF_NB_ADDR-1:0] addr;
        rf_data_u               data;
    } gpio_cmd_t;

    // write request, valid for a single cycle
    typedef struct packed {
        logic                   valid;
        logic [`RF_NB_ADDR-1:0] addr;
        rf_data_u               data;
    } rf_wr_t;

    typedef struct packed {
        logic                        pcs_reset;
        logic                        loopback;
        logic                        idle_mode;
        logic                        clock_comp_enb;
        logic [`RF_NB_TX_ENB-1:0]    tx_enb;
        logic                        tx_scrambler_bypass;
        logic [`RF_NB_RX_ENB-1:0]    rx_enb;
        logic                        rx_descrambler_bypass;
        logic [`RF_NB_WINDOW-1:0]    locked_timer_limit;
        logic [`RF_NB_WINDOW-1:0]    unlocked_timer_limit;
        logic [`RF_NB_INVALID-1:0]   sh_invalid_limit;
        logic [`RF_NB_INV_AM-1:0]    invalid_am_thr;
        logic [`RF_NB_VAL_AM-1:0]    valid_am_thr;
        logic [`RF_NB_AM_PERIOD-1:0] am_period;
        // single-cycle pulses
        logic                        reset_order;
        logic [`RF_N_LANES-1:0]      bit_skew_update;
        logic [`RF_NB_SKEW-1:0]      bit_skew_index;
    } rf_ctrl_t;

    typedef struct packed {
        logic [`RF_N_LANES-1:0]                         block_lock;
        logic [`RF_N_LANES-1:0]                         am_lock;
        logic [`RF_N_LANES-1:0]                         hi_ber;
        logic                                           deskew_done;
        logic [`RF_NB_COUNTER-1:0]                      mismatch_count;
        logic [`RF_NB_COUNTER-1:0]                      decoder_error_count;
        logic [`RF_N_LANES-1:0][`RF_NB_LANE_ID-1:0]     lane_id;
    } rf_status_t;

endpackage

//--- src/rf_cmd_fsm.sv
`include "rf_config.svh"

module rf_cmd_fsm (
    input  logic                   i_fpga_clock,
    input  logic                   i_rst_n,
    input  rf_pkg::gpio_cmd_t      i_gpio_data,
    output rf_pkg::rf_wr_t         o_wr,
    output logic [`RF_NB_ADDR-1:0] o_rd_addr
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_LOW
    } state_t;

    rf_pkg::gpio_cmd_t      gpio_s1;
    rf_pkg::gpio_cmd_t      gpio_s2;
    state_t                 state;
    state_t                 next_state;
    logic [`RF_NB_ADDR-1:0] wr_addr;
    rf_pkg::rf_data_u       wr_data;

    // two stage synchronizer for the whole gpio word
    always_ff @(posedge i_fpga_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gpio_s1 <= '0;
            gpio_s2 <= '0;
        end else begin
            gpio_s1 <= i_gpio_data;
            gpio_s2 <= gpio_s1;
        end
    end

    always_ff @(posedge i_fpga_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (gpio_s2.strobe) begin
                    next_state = ISSUE;
                end
            end
            // one write per rise
            ISSUE: begin
                next_state = WAIT_LOW;
            end
            // re-arm only once strobe is seen low
            WAIT_LOW: begin
                if (!gpio_s2.strobe) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // latch addr and data on the rising edge
    always_ff @(posedge i_fpga_clock) begin
        if (state == IDLE && gpio_s2.strobe) begin
            wr_addr <= gpio_s2.addr;
            wr_data <= gpio_s2.data;
        end
    end

    always_comb begin
        o_wr.valid = (state == ISSUE);
        o_wr.addr  = wr_addr;
        o_wr.data  = wr_data;
    end

    // reads follow the synchronized address continuously
    assign o_rd_addr = gpio_s2.addr;

endmodule

//--- src/rf_pulse_timer.sv
`include "rf_config.svh"

module rf_pulse_timer (
    input  logic i_fpga_clock,
    input  logic i_rst_n,
    input  logic i_start,
    output logic o_busy
);

    localparam int NB_COUNT = $clog2(`RF_PCS_RESET_CYCLES + 1);
    localparam logic [NB_COUNT-1:0] HOLD_CYCLES = NB_COUNT'(`RF_PCS_RESET_CYCLES);

    logic [NB_COUNT-1:0] count;

    // loaded on reset too, so the pcs sees a reset pulse at power-up
    always_ff @(posedge i_fpga_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= HOLD_CYCLES;
        end else if (i_start) begin
            // restart while busy reloads the full hold time
            count <= HOLD_CYCLES;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign o_busy = (count != '0);

endmodule

//--- src/rf_write.sv
`include "rf_config.svh"

module rf_write (
    input  logic             i_fpga_clock,
    input  logic             i_rst_n,
    input  rf_pkg::rf_wr_t   i_wr,
    output rf_pkg::rf_ctrl_t o_ctrl,
    output logic             o_reset_start
);

    localparam logic [`RF_NB_LANE_ID-1:0] LANE_LIMIT = `RF_NB_LANE_ID'(`RF_N_LANES);

    always_ff @(posedge i_fpga_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ctrl        <= '0;
            o_reset_start <= 1'b0;
        end else begin
            // pulses last one cycle
            o_ctrl.reset_order     <= 1'b0;
            o_ctrl.bit_skew_update <= '0;
            o_reset_start          <= 1'b0;

            if (i_wr.valid) begin
                case (i_wr.addr)
                    `RF_ADDR_GLOBAL: begin
                        // bit 0 requests a timed pcs reset, not stored here
                        o_reset_start  <= i_wr.data.raw[0];
                        o_ctrl.loopback       <= i_wr.data.raw[1];
                        o_ctrl.idle_mode      <= i_wr.data.raw[2];
                        o_ctrl.clock_comp_enb <= i_wr.data.raw[3];
                    end
                    `RF_ADDR_TX_ENB: begin
                        {o_ctrl.tx_scrambler_bypass, o_ctrl.tx_enb} <=
                            i_wr.data.raw[`RF_NB_TX_ENB:0];
                    end
                    `RF_ADDR_RX_ENB: begin
                        {o_ctrl.rx_descrambler_bypass, o_ctrl.rx_enb} <=
                            i_wr.data.raw[`RF_NB_RX_ENB:0];
                    end
                    `RF_ADDR_LOCKED_TMR: begin
                        o_ctrl.locked_timer_limit <= i_wr.data.raw[`RF_NB_WINDOW-1:0];
                    end
                    `RF_ADDR_UNLOCKED_TMR: begin
                        o_ctrl.unlocked_timer_limit <= i_wr.data.raw[`RF_NB_WINDOW-1:0];
                    end
                    `RF_ADDR_SH_INVALID: begin
                        o_ctrl.sh_invalid_limit <= i_wr.data.raw[`RF_NB_INVALID-1:0];
                    end
                    // thresholds low, period in the top 14 bits
                    `RF_ADDR_ALIGNER: begin
                        {o_ctrl.am_period, o_ctrl.valid_am_thr, o_ctrl.invalid_am_thr} <=
                            i_wr.data.raw;
                    end
                    `RF_ADDR_RESET_ORDER: begin
                        o_ctrl.reset_order <= 1'b1;
                    end
                    `RF_ADDR_BIT_SKEW: begin
                        // lanes past the last one are dropped
                        if (i_wr.data.lane_cmd.lane < LANE_LIMIT) begin
                            o_ctrl.bit_skew_index  <= i_wr.data.lane_cmd.skew;
                            o_ctrl.bit_skew_update <=
                                `RF_N_LANES'(1) << i_wr.data.lane_cmd.lane;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- src/rf_read_mux.sv
`include "rf_config.svh"

module rf_read_mux (
    input  logic                   i_fpga_clock,
    input  logic                   i_rst_n,
    input  logic [`RF_NB_ADDR-1:0] i_rd_addr,
    input  rf_pkg::rf_ctrl_t       i_ctrl,
    input  logic                   i_reset_busy,
    input  rf_pkg::rf_status_t     i_status,
    output logic [`RF_NB_GPIO-1:0] o_gpio_data
);

    rf_pkg::rf_status_t     status_s1;
    rf_pkg::rf_status_t     status_s2;
    rf_pkg::rf_data_u       rd_value;
    logic [`RF_NB_DATA-1:0] rd_q;

    // status comes from the pcs side, resync before muxing
    always_ff @(posedge i_fpga_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            status_s1 <= '0;
            status_s2 <= '0;
        end else begin
            status_s1 <= i_status;
            status_s2 <= status_s1;
        end
    end

    always_comb begin
        logic [`RF_NB_ADDR-1:0]    offset;
        logic [`RF_NB_LANE_ID-1:0] lane_sel;

        offset   = i_rd_addr - `RF_NB_ADDR'(`RF_ADDR_STATUS_BASE);
        lane_sel = `RF_NB_LANE_ID'(offset - `RF_NB_ADDR'(`RF_ST_LANE_ID_BASE));
        rd_value = '0;

        if (i_rd_addr < `RF_NB_ADDR'(`RF_ADDR_STATUS_BASE)) begin
            case (i_rd_addr)
                // busy flag stands in for the pcs_reset bit
                `RF_ADDR_GLOBAL: rd_value.raw[3:0] =
                    {i_ctrl.clock_comp_enb, i_ctrl.idle_mode, i_ctrl.loopback, i_reset_busy};
                `RF_ADDR_TX_ENB: rd_value.raw[`RF_NB_TX_ENB:0] =
                    {i_ctrl.tx_scrambler_bypass, i_ctrl.tx_enb};
                `RF_ADDR_RX_ENB: rd_value.raw[`RF_NB_RX_ENB:0] =
                    {i_ctrl.rx_descrambler_bypass, i_ctrl.rx_enb};
                `RF_ADDR_LOCKED_TMR: rd_value.raw[`RF_NB_WINDOW-1:0] = i_ctrl.locked_timer_limit;
                `RF_ADDR_UNLOCKED_TMR: rd_value.raw[`RF_NB_WINDOW-1:0] =
                    i_ctrl.unlocked_timer_limit;
                `RF_ADDR_SH_INVALID: rd_value.raw[`RF_NB_INVALID-1:0] = i_ctrl.sh_invalid_limit;
                `RF_ADDR_ALIGNER: rd_value.raw =
                    {i_ctrl.am_period, i_ctrl.valid_am_thr, i_ctrl.invalid_am_thr};
                // lane field reads as zero, only the index is kept
                `RF_ADDR_BIT_SKEW: rd_value.lane_cmd.skew = i_ctrl.bit_skew_index;
                default: rd_value = '0;
            endcase
        end else begin
            case (offset)
                `RF_ST_BLOCK_LOCK: rd_value.raw[`RF_N_LANES-1:0] = status_s2.block_lock;
                `RF_ST_AM_LOCK: rd_value.raw[`RF_N_LANES-1:0] = status_s2.am_lock;
                `RF_ST_HI_BER: rd_value.raw[`RF_N_LANES-1:0] = status_s2.hi_ber;
                `RF_ST_DESKEW_DONE: rd_value.raw[0] = status_s2.deskew_done;
                `RF_ST_MISMATCH: rd_value.raw[`RF_NB_COUNTER-1:0] = status_s2.mismatch_count;
                `RF_ST_DECODER_ERR: rd_value.raw[`RF_NB_COUNTER-1:0] =
                    status_s2.decoder_error_count;
                default: begin
                    if (offset >= `RF_ST_LANE_ID_BASE &&
                        offset < `RF_ST_LANE_ID_BASE + `RF_N_LANES) begin
                        rd_value.raw[`RF_NB_LANE_ID-1:0] = status_s2.lane_id[lane_sel];
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_fpga_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_q <= '0;
        end else begin
            rd_q <= rd_value.raw;
        end
    end

    // upper gpio bits always read zero
    assign o_gpio_data = {{(`RF_NB_GPIO - `RF_NB_DATA){1'b0}}, rd_q};

endmodule

//--- src/rf_toplevel.sv
`include "rf_config.svh"

module rf_toplevel (
    input  logic                   i_fpga_clock,
    input  logic                   i_rst_n,
    input  rf_pkg::gpio_cmd_t      i_gpio_data,
    output logic [`RF_NB_GPIO-1:0] o_gpio_data,
    output rf_pkg::rf_ctrl_t       o_pcs_ctrl,
    input  rf_pkg::rf_status_t     i_pcs_status
);

    rf_pkg::rf_wr_t         wr;
    rf_pkg::rf_ctrl_t       wr_ctrl;
    logic [`RF_NB_ADDR-1:0] rd_addr;
    logic                   reset_start;
    logic                   reset_busy;

    rf_cmd_fsm u_rf_cmd_fsm (
        .i_fpga_clock (i_fpga_clock),
        .i_rst_n      (i_rst_n),
        .i_gpio_data  (i_gpio_data),
        .o_wr         (wr),
        .o_rd_addr    (rd_addr)
    );

    rf_write u_rf_write (
        .i_fpga_clock  (i_fpga_clock),
        .i_rst_n       (i_rst_n),
        .i_wr          (wr),
        .o_ctrl        (wr_ctrl),
        .o_reset_start (reset_start)
    );

    rf_pulse_timer u_rf_pulse_timer (
        .i_fpga_clock (i_fpga_clock),
        .i_rst_n      (i_rst_n),
        .i_start      (reset_start),
        .o_busy       (reset_busy)
    );

    rf_read_mux u_rf_read_mux (
        .i_fpga_clock (i_fpga_clock),
        .i_rst_n      (i_rst_n),
        .i_rd_addr    (rd_addr),
        .i_ctrl       (wr_ctrl),
        .i_reset_busy (reset_busy),
        .i_status     (i_pcs_status),
        .o_gpio_data  (o_gpio_data)
    );

    // pcs reset is the timed pulse, everything else straight from the bank
    always_comb begin
        o_pcs_ctrl           = wr_ctrl;
        o_pcs_ctrl.pcs_reset = reset_busy;
    end

endmodule

//--- tests/rf_toplevel_sva.sv
`include "rf_config.svh"

module rf_toplevel_sva (
    input logic             i_fpga_clock,
    input logic             i_rst_n,
    input rf_pkg::rf_wr_t   i_wr,
    input rf_pkg::rf_ctrl_t i_pcs_ctrl,
    input logic             i_reset_start,
    input logic             i_reset_busy
);

    // one write request per strobe rise
    a_wr_single: assert property (@(posedge i_fpga_clock) disable iff (!i_rst_n)
        i_wr.valid |=> !i_wr.valid)
        else $error("write request lasted more than one cycle");

    a_order_pulse: assert property (@(posedge i_fpga_clock) disable iff (!i_rst_n)
        i_pcs_ctrl.reset_order |=> !i_pcs_ctrl.reset_order)
        else $error("reset_order pulse lasted more than one cycle");

    // lane update gone on the next cycle
    a_update_pulse: assert property (@(posedge i_fpga_clock) disable iff (!i_rst_n)
        (i_pcs_ctrl.bit_skew_update != '0) |=> (i_pcs_ctrl.bit_skew_update == '0))
        else $error("bit_skew_update lasted more than one cycle");

    a_reset_len: assert property (@(posedge i_fpga_clock) disable iff (!i_rst_n)
        i_reset_start |=> i_reset_busy [*`RF_PCS_RESET_CYCLES] ##1 !i_reset_busy)
        else $error("pcs reset pulse has the wrong length");

endmodule

bind rf_toplevel rf_toplevel_sva u_rf_toplevel_sva (
    .i_fpga_clock  (i_fpga_clock),
    .i_rst_n       (i_rst_n),
    .i_wr          (wr),
    .i_pcs_ctrl    (o_pcs_ctrl),
    .i_reset_start (reset_start),
    .i_reset_busy  (reset_busy)
);

//--- tests/tb_rf_toplevel.sv
`include "rf_config.svh"

module tb_rf_toplevel;

    localparam int MAX_TESTS = 64;
    localparam int N_COLS    = 5;

    logic                   i_fpga_clock;
    logic                   i_rst_n;
    rf_pkg::gpio_cmd_t      gpio_cmd;
    logic [`RF_NB_GPIO-1:0] gpio_rd;
    rf_pkg::rf_ctrl_t       pcs_ctrl;
    rf_pkg::rf_status_t     pcs_status;

    logic [31:0]               stim [0:MAX_TESTS*N_COLS-1];
    logic [`RF_NB_LANE_ID-1:0] lane_exp [0:`RF_N_LANES-1];
    rf_pkg::rf_ctrl_t          model;
    int                        n_tests = 0;
    int                        n_failed = 0;
    int                        errors = 0;
    int                        order_pulses = 0;

    rf_toplevel uut (
        .i_fpga_clock (i_fpga_clock),
        .i_rst_n      (i_rst_n),
        .i_gpio_data  (gpio_cmd),
        .o_gpio_data  (gpio_rd),
        .o_pcs_ctrl   (pcs_ctrl),
        .i_pcs_status (pcs_status)
    );

    initial begin
        i_fpga_clock = 1'b0;
        forever #4 i_fpga_clock = ~i_fpga_clock;
    end

    // budget of 40 cycles per test plus some slack
    initial begin
        wait (n_tests > 0);
        repeat ((n_tests + 4) * 40) @(posedge i_fpga_clock);
        $display("timeout: tests still running after %0d cycles", (n_tests + 4) * 40);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected register bank after one write, per the address map
    function automatic rf_pkg::rf_ctrl_t apply_write(input rf_pkg::rf_ctrl_t c,
            input logic [`RF_NB_ADDR-1:0] a, input rf_pkg::rf_data_u d);
        rf_pkg::rf_ctrl_t n;
        n = c;
        case (a)
            `RF_ADDR_GLOBAL: {n.clock_comp_enb, n.idle_mode, n.loopback} = d.raw[3:1];
            `RF_ADDR_TX_ENB: {n.tx_scrambler_bypass, n.tx_enb} = d.raw[6:0];
            `RF_ADDR_RX_ENB: {n.rx_descrambler_bypass, n.rx_enb} = d.raw[7:0];
            `RF_ADDR_LOCKED_TMR: n.locked_timer_limit = d.raw[11:0];
            `RF_ADDR_UNLOCKED_TMR: n.unlocked_timer_limit = d.raw[11:0];
            `RF_ADDR_SH_INVALID: n.sh_invalid_limit = d.raw[10:0];
            `RF_ADDR_ALIGNER: {n.am_period, n.valid_am_thr, n.invalid_am_thr} = d.raw;
            `RF_ADDR_BIT_SKEW: begin
                if (d.lane_cmd.lane < `RF_N_LANES) begin
                    n.bit_skew_index = d.lane_cmd.skew;
                end
            end
            default: begin
            end
        endcase
        return n;
    endfunction

    task automatic check_gpio(input string name, input logic [`RF_NB_GPIO-1:0] got,
            input logic [`RF_NB_GPIO-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_ctrl(input rf_pkg::rf_ctrl_t got, input rf_pkg::rf_ctrl_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: o_pcs_ctrl got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_update(input logic [`RF_N_LANES-1:0] got,
            input logic [`RF_N_LANES-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: o_pcs_ctrl.bit_skew_update got %h expected %h",
                $time, got, exp);
            errors++;
        end
    endtask

    task automatic send_cmd(input logic strobe, input logic [`RF_NB_ADDR-1:0] addr,
            input logic [`RF_NB_DATA-1:0] data);
        @(posedge i_fpga_clock);
        #1;
        gpio_cmd.strobe   = strobe;
        gpio_cmd.addr     = addr;
        gpio_cmd.data.raw = data;
    endtask

    // strobe rise, then past the register update and its readback
    task automatic write_reg(input logic [`RF_NB_ADDR-1:0] addr,
            input logic [`RF_NB_DATA-1:0] data);
        send_cmd(1'b0, addr, data);
        send_cmd(1'b1, addr, data);
        order_pulses = 0;
        repeat (7) begin
            @(negedge i_fpga_clock);
            if (pcs_ctrl.reset_order) begin
                order_pulses++;
            end
        end
    endtask

    task automatic release_strobe(input logic [`RF_NB_ADDR-1:0] addr,
            input logic [`RF_NB_DATA-1:0] data);
        send_cmd(1'b0, addr, data);
        repeat (3) @(posedge i_fpga_clock);
    endtask

    task automatic settle_read();
        repeat (4) @(posedge i_fpga_clock);
        @(negedge i_fpga_clock);
    endtask

    task automatic load_status(input logic [`RF_NB_ADDR-1:0] offset, input logic [31:0] img);
        case (offset)
            `RF_ST_BLOCK_LOCK: pcs_status.block_lock = img[`RF_N_LANES-1:0];
            `RF_ST_AM_LOCK: pcs_status.am_lock = img[`RF_N_LANES-1:0];
            `RF_ST_HI_BER: pcs_status.hi_ber = img[`RF_N_LANES-1:0];
            `RF_ST_DESKEW_DONE: pcs_status.deskew_done = img[0];
            `RF_ST_MISMATCH: pcs_status.mismatch_count = img[`RF_NB_COUNTER-1:0];
            `RF_ST_DECODER_ERR: pcs_status.decoder_error_count = img[`RF_NB_COUNTER-1:0];
            default: begin
            end
        endcase
    endtask

    task automatic report_test(input int num, input string label, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d %s: ok", num, label);
        end else begin
            $display("test %0d %s: failed", num, label);
            n_failed++;
        end
    endtask

    initial begin
        int                     op;
        int                     cnt;
        int                     errs_before;
        int                     pulses;
        int                     high;
        logic [`RF_NB_ADDR-1:0] addr;
        rf_pkg::rf_data_u       data;
        rf_pkg::rf_data_u       sk;
        rf_pkg::rf_ctrl_t       exp_ctrl;
        logic [31:0]            img;
        logic [31:0]            expv;
        logic [31:0]            seed;
        logic [`RF_N_LANES-1:0] seen;

        i_rst_n    = 1'b0;
        gpio_cmd   = '0;
        pcs_status = '0;
        model      = '0;
        seed       = 32'h0e95_f572;
        for (int n = 0; n < `RF_N_LANES; n++) begin
            seed = xorshift32(seed);
            lane_exp[n] = seed[`RF_NB_LANE_ID-1:0];
            pcs_status.lane_id[n] = seed[`RF_NB_LANE_ID-1:0];
        end
        $readmemh("tests/rf_stim.txt", stim);
        cnt = 0;
        while (cnt < MAX_TESTS && stim[cnt*N_COLS] !== 'x) begin
            cnt++;
        end
        if (cnt == 0) begin
            $display("no stimulus lines could be read from tests/rf_stim.txt");
            errors++;
        end
        n_tests = cnt;

        repeat (3) @(posedge i_fpga_clock);
        #1;
        i_rst_n = 1'b1;

        // power-up reset pulse, everything else idle
        errs_before = errors;
        exp_ctrl = '0;
        exp_ctrl.pcs_reset = 1'b1;
        check_gpio("o_gpio_data", gpio_rd, '0);
        check_ctrl(pcs_ctrl, exp_ctrl);
        high = 0;
        repeat (24) begin
            @(negedge i_fpga_clock);
            if (pcs_ctrl.pcs_reset) begin
                high++;
            end
        end
        if (high != `RF_PCS_RESET_CYCLES) begin
            $display("power-up pcs reset held for %0d cycles, not %0d", high,
                `RF_PCS_RESET_CYCLES);
            errors++;
        end
        check_ctrl(pcs_ctrl, model);
        report_test(0, "power-up reset", errs_before);

        for (int t = 0; t < n_tests; t++) begin
            op          = stim[t*N_COLS];
            addr        = stim[t*N_COLS+1][`RF_NB_ADDR-1:0];
            data.raw    = stim[t*N_COLS+2][`RF_NB_DATA-1:0];
            img         = stim[t*N_COLS+3];
            expv        = stim[t*N_COLS+4];
            errs_before = errors;
            case (op)
                0: begin
                    write_reg(addr, data.raw);
                    model = apply_write(model, addr, data);
                    check_ctrl(pcs_ctrl, model);
                    check_gpio("o_gpio_data", gpio_rd, expv);
                    // only the reset order address fires its pulse, and just once
                    if (order_pulses != int'(addr == `RF_ADDR_RESET_ORDER)) begin
                        $display("reset_order pulse was seen for %0d cycles", order_pulses);
                        errors++;
                    end
                    release_strobe(addr, data.raw);
                end
                1: begin
                    send_cmd(1'b0, addr, '0);
                    settle_read();
                    check_gpio("o_gpio_data", gpio_rd, expv);
                end
                2: begin
                    send_cmd(1'b0, addr, '0);
                    load_status(addr - `RF_NB_ADDR'(`RF_ADDR_STATUS_BASE), img);
                    settle_read();
                    check_gpio("o_gpio_data", gpio_rd, expv);
                end
                3: begin
                    send_cmd(1'b0, addr, data.raw);
                    send_cmd(1'b1, addr, data.raw);
                    seen   = '0;
                    pulses = 0;
                    repeat (8) begin
                        @(negedge i_fpga_clock);
                        seen |= pcs_ctrl.bit_skew_update;
                        if (pcs_ctrl.bit_skew_update != '0) begin
                            pulses++;
                        end
                    end
                    model = apply_write(model, addr, data);
                    check_update(seen, expv[`RF_N_LANES-1:0]);
                    if (pulses != int'(expv != 32'h0)) begin
                        $display("lane update pulse was seen for %0d cycles", pulses);
                        errors++;
                    end
                    check_ctrl(pcs_ctrl, model);
                    sk = '0;
                    sk.lane_cmd.skew = model.bit_skew_index;
                    check_gpio("o_gpio_data", gpio_rd, 32'(sk.raw));
                    release_strobe(addr, data.raw);
                end
                4: begin
                    for (int n = 0; n < `RF_N_LANES; n++) begin
                        send_cmd(1'b0, addr + `RF_NB_ADDR'(n), '0);
                        settle_read();
                        check_gpio($sformatf("o_gpio_data lane %0d", n), gpio_rd,
                            32'(lane_exp[n]));
                    end
                end
                5: begin
                    // first value from the status column, second one while strobe stays high
                    write_reg(addr, img[`RF_NB_DATA-1:0]);
                    model = apply_write(model, addr, img[`RF_NB_DATA-1:0]);
                    send_cmd(1'b1, addr, data.raw);
                    repeat (6) @(posedge i_fpga_clock);
                    @(negedge i_fpga_clock);
                    check_ctrl(pcs_ctrl, model);
                    check_gpio("o_gpio_data", gpio_rd, img);
                    release_strobe(addr, data.raw);
                    write_reg(addr, data.raw);
                    model = apply_write(model, addr, data);
                    check_ctrl(pcs_ctrl, model);
                    check_gpio("o_gpio_data", gpio_rd, expv);
                    release_strobe(addr, data.raw);
                end
                6: begin
                    send_cmd(1'b0, addr, data.raw);
                    send_cmd(1'b1, addr, data.raw);
                    high = 0;
                    repeat (30) begin
                        @(negedge i_fpga_clock);
                        if (pcs_ctrl.pcs_reset) begin
                            high++;
                            if (high == 4) begin
                                check_gpio("o_gpio_data", gpio_rd, expv);
                            end
                        end
                    end
                    if (high != `RF_PCS_RESET_CYCLES) begin
                        $display("pcs reset held for %0d cycles, not %0d", high,
                            `RF_PCS_RESET_CYCLES);
                        errors++;
                    end
                    model = apply_write(model, addr, data);
                    check_ctrl(pcs_ctrl, model);
                    check_gpio("o_gpio_data", gpio_rd, expv & ~32'h1);
                    release_strobe(addr, data.raw);
                end
                default: begin
                    $display("unknown operation %0d in stimulus line %0d", op, t + 1);
                    errors++;
                end
            endcase
            report_test(t + 1, $sformatf("op %0d addr %03h", op, addr), errs_before);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors", n_tests + 1,
            n_tests + 1 - n_failed, n_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tests/rf_stim.txt
// op addr data status_image expected, all hex
// op 0 write, 1 read config, 2 read status, 3 lane update, 4 lane-id sweep, 5 held strobe, 6 pcs reset
0 000 0000000e 00000000 0000000e
0 001 003fffff 00000000 0000007f
0 002 000000a5 00000000 000000a5
0 003 00000abc 00000000 00000abc
0 004 00012345 00000000 00000345
0 005 00000fff 00000000 000007ff
0 006 002bcdef 00000000 002bcdef
0 007 00000001 00000000 00000000
1 008 00000000 00000000 00000000
1 001 00000000 00000000 0000007f
3 010 000000a3 00000000 00000008
3 010 00000273 00000000 00080000
3 010 00000fd4 00000000 00000000
2 100 000a5a5a 000a5a5a 000a5a5a
2 102 00000000 000fffff 000fffff
2 103 00000000 00000001 00000001
2 104 00000000 0000beef 0000beef
2 105 00000000 00001234 00001234
2 106 00000000 ffffffff 00000000
2 11c 00000000 00000000 00000000
4 108 00000000 00000000 00000000
5 006 00000111 00000222 00000111
6 000 00000009 00000000 00000009

//--- sources.f
+incdir+src
src/rf_pkg.sv
src/rf_cmd_fsm.sv
src/rf_pulse_timer.sv
src/rf_write.sv
src/rf_read_mux.sv
src/rf_toplevel.sv
tests/rf_toplevel_sva.sv
tests/tb_rf_toplevel.sv

//--- Bender.yml
package:
  name: rf_toplevel

sources:
  - include_dirs:
      - src
    files:
      - src/rf_pkg.sv
      - src/rf_cmd_fsm.sv
      - src/rf_pulse_timer.sv
      - src/rf_write.sv
      - src/rf_read_mux.sv
      - src/rf_toplevel.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/rf_toplevel_sva.sv
      - tests/tb_rf_toplevel.sv
